/* src/ipod_pkg.sv */
package ipod_pkg;

  // ==========================================================================
  // Bus and sample widths
  // ==========================================================================

  localparam int FLASH_ADDR_W = 23;
  localparam int FLASH_DATA_W = 32;
  localparam int SAMPLE_W     = 8;
  localparam int PERIOD_W     = 16;

  // ==========================================================================
  // Keyboard command codes (ASCII)
  // ==========================================================================

  localparam logic [7:0] CMD_PLAY     = 8'h45;  // 'E'
  localparam logic [7:0] CMD_STOP     = 8'h44;  // 'D'
  localparam logic [7:0] CMD_FORWARD  = 8'h46;  // 'F'
  localparam logic [7:0] CMD_BACKWARD = 8'h42;  // 'B'
  localparam logic [7:0] CMD_RESTART  = 8'h52;  // 'R'

  // ==========================================================================
  // Flash word views
  // ==========================================================================

  // Raw bus word, or two 16-bit sample halves
  // half[0] is the low half, half[1] the high half
  // Each half carries its sample in the upper byte
  typedef union packed {
    logic [FLASH_DATA_W-1:0]          raw;
    logic [1:0][FLASH_DATA_W/2-1:0]   half;
  } flash_word_t;

endpackage

/* src/kbd_command_decoder.sv */
`timescale 1ns/100ps

module kbd_command_decoder (
  input  logic       CLK_50M,
  input  logic       rst,
  input  logic [7:0] cmd_ascii,
  input  logic       cmd_valid,
  output logic       play,
  output logic       reverse,
  output logic       restart
);

  // Play and direction are held levels, restart is a single pulse
  always_ff @(posedge CLK_50M) begin
    if (rst) begin
      play    <= 1'b0;
      reverse <= 1'b0;
      restart <= 1'b0;
    end else begin
      restart <= 1'b0;
      if (cmd_valid) begin
        case (cmd_ascii)
          ipod_pkg::CMD_PLAY: begin
            play <= 1'b1;
          end
          ipod_pkg::CMD_STOP: begin
            play <= 1'b0;
          end
          ipod_pkg::CMD_FORWARD: begin
            reverse <= 1'b0;
          end
          ipod_pkg::CMD_BACKWARD: begin
            reverse <= 1'b1;
          end
          ipod_pkg::CMD_RESTART: begin
            restart <= 1'b1;
          end
          default: begin
            // Any other key is ignored
          end
        endcase
      end
    end
  end

endmodule

/* src/playback_speed_control.sv */
`timescale 1ns/100ps

module playback_speed_control #(
  parameter int DEFAULT_SAMPLE_DIV = 1136,
  parameter int SPEED_STEP         = 100
) (
  input  logic                          CLK_50M,
  input  logic                          rst,
  input  logic                          speed_up,
  input  logic                          speed_down,
  input  logic                          speed_reset,
  output logic [ipod_pkg::PERIOD_W-1:0] sample_period
);

  // Two guard bits so the step never wraps before the clamp
  localparam int OFS_W      = ipod_pkg::PERIOD_W + 2;
  localparam int MIN_OFFSET = SPEED_STEP - DEFAULT_SAMPLE_DIV;
  localparam int MAX_OFFSET = DEFAULT_SAMPLE_DIV;

  localparam logic [ipod_pkg::PERIOD_W-1:0] DEFAULT_DIV =
    DEFAULT_SAMPLE_DIV[ipod_pkg::PERIOD_W-1:0];

  logic signed [ipod_pkg::PERIOD_W-1:0] offset;
  logic signed [OFS_W-1:0]              offset_next;

  // Faster means a shorter period
  always_comb begin
    if (speed_up) begin
      offset_next = OFS_W'(offset) - OFS_W'(SPEED_STEP);
    end else if (speed_down) begin
      offset_next = OFS_W'(offset) + OFS_W'(SPEED_STEP);
    end else begin
      offset_next = OFS_W'(offset);
    end

    // Keep period within SPEED_STEP .. 2 * DEFAULT_SAMPLE_DIV
    if (offset_next < OFS_W'(MIN_OFFSET)) begin
      offset_next = OFS_W'(MIN_OFFSET);
    end else if (offset_next > OFS_W'(MAX_OFFSET)) begin
      offset_next = OFS_W'(MAX_OFFSET);
    end
  end

  always_ff @(posedge CLK_50M) begin
    if (rst || speed_reset) begin
      offset <= '0;
    end else begin
      offset <= offset_next[ipod_pkg::PERIOD_W-1:0];
    end
  end

  assign sample_period = DEFAULT_DIV + offset;

endmodule

/* src/sample_tick_gen.sv */
`timescale 1ns/100ps

module sample_tick_gen (
  input  logic                          CLK_50M,
  input  logic                          rst,
  input  logic [ipod_pkg::PERIOD_W-1:0] sample_period,
  output logic                          tick
);

  logic [ipod_pkg::PERIOD_W-1:0] count;

  // Counts period-1 down to zero, so one tick every sample_period cycles
  // The period is only sampled at the reload
  always_ff @(posedge CLK_50M) begin
    if (rst) begin
      count <= '0;
      tick  <= 1'b0;
    end else if (count == '0) begin
      count <= sample_period - 1'b1;
      tick  <= 1'b1;
    end else begin
      count <= count - 1'b1;
      tick  <= 1'b0;
    end
  end

endmodule

/* src/flash_word_reader.sv */
`timescale 1ns/100ps

module flash_word_reader (
  input  logic                              CLK_50M,
  input  logic                              rst,
  input  logic                              fetch_req,
  input  logic [ipod_pkg::FLASH_ADDR_W-1:0] fetch_addr,
  output logic                              flash_read,
  output logic [ipod_pkg::FLASH_ADDR_W-1:0] flash_address,
  input  logic                              flash_waitrequest,
  input  logic [ipod_pkg::FLASH_DATA_W-1:0] flash_readdata,
  input  logic                              flash_readdatavalid,
  output ipod_pkg::flash_word_t             fetch_word,
  output logic                              fetch_done
);

  localparam logic [1:0] ST_IDLE      = 2'd0;
  localparam logic [1:0] ST_REQUEST   = 2'd1;
  localparam logic [1:0] ST_WAIT_DATA = 2'd2;

  logic [1:0] state;

  // ==========================================================================
  // Read FSM, one outstanding read
  // ==========================================================================

  always_ff @(posedge CLK_50M) begin
    if (rst) begin
      state      <= ST_IDLE;
      flash_read <= 1'b0;
      fetch_done <= 1'b0;
    end else begin
      fetch_done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (fetch_req) begin
            flash_read <= 1'b1;
            state      <= ST_REQUEST;
          end
        end
        ST_REQUEST: begin
          // Read is accepted in the cycle waitrequest is low
          if (!flash_waitrequest) begin
            flash_read <= 1'b0;
            state      <= ST_WAIT_DATA;
          end
        end
        ST_WAIT_DATA: begin
          if (flash_readdatavalid) begin
            fetch_done <= 1'b1;
            state      <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Address held stable for the whole request, word captured on valid
  always_ff @(posedge CLK_50M) begin
    if (state == ST_IDLE && fetch_req) begin
      flash_address <= fetch_addr;
    end
    if (state == ST_WAIT_DATA && flash_readdatavalid) begin
      fetch_word.raw <= flash_readdata;
    end
  end

endmodule

/* src/sample_sequencer.sv */
`timescale 1ns/100ps

module sample_sequencer #(
  parameter int LAST_WORD_ADDR = 'h7FFFF
) (
  input  logic                              CLK_50M,
  input  logic                              rst,
  input  logic                              play,
  input  logic                              reverse,
  input  logic                              restart,
  input  logic                              tick,
  output logic                              fetch_req,
  output logic [ipod_pkg::FLASH_ADDR_W-1:0] fetch_addr,
  input  ipod_pkg::flash_word_t             fetch_word,
  input  logic                              fetch_done,
  output logic [ipod_pkg::SAMPLE_W-1:0]     audio_data,
  output logic                              audio_valid,
  output logic                              playing
);

  localparam int HALF_W = ipod_pkg::FLASH_DATA_W / 2;
  localparam logic [ipod_pkg::FLASH_ADDR_W-1:0] LAST_ADDR =
    LAST_WORD_ADDR[ipod_pkg::FLASH_ADDR_W-1:0];

  // addr is the next word to fetch
  logic [ipod_pkg::FLASH_ADDR_W-1:0] addr;
  logic [ipod_pkg::FLASH_ADDR_W-1:0] next_addr;
  ipod_pkg::flash_word_t             cur_word;
  logic                              cur_valid;
  logic                              next_valid;
  logic                              pending;
  logic                              drop;
  logic                              half_idx;
  logic                              half_sel;
  logic                              issue;
  logic                              load;
  logic                              consume;

  // Address step with wrap in either direction
  always_comb begin
    if (reverse) begin
      next_addr = (addr == '0) ? LAST_ADDR : addr - 1'b1;
    end else begin
      next_addr = (addr == LAST_ADDR) ? '0 : addr + 1'b1;
    end
  end

  // The fetched word stays in the reader as the second buffer
  assign issue    = !restart && !pending && !next_valid;
  assign load     = !restart && !cur_valid && next_valid;
  assign consume  = !restart && tick && play && cur_valid;
  assign half_sel = half_idx ^ reverse;
  assign playing  = play;

  always_ff @(posedge CLK_50M) begin
    if (rst) begin
      addr        <= '0;
      cur_valid   <= 1'b0;
      next_valid  <= 1'b0;
      pending     <= 1'b0;
      drop        <= 1'b0;
      half_idx    <= 1'b0;
      fetch_req   <= 1'b0;
      audio_valid <= 1'b0;
    end else begin
      fetch_req   <= issue;
      audio_valid <= consume;
      if (fetch_done) begin
        pending <= 1'b0;
        drop    <= 1'b0;
      end
      if (restart) begin
        addr       <= reverse ? LAST_ADDR : '0;
        cur_valid  <= 1'b0;
        next_valid <= 1'b0;
        half_idx   <= 1'b0;
        // A read still in flight belongs to the old position
        drop       <= pending && !fetch_done;
      end else begin
        if (fetch_done && !drop) begin
          next_valid <= 1'b1;
        end
        if (issue) begin
          addr    <= next_addr;
          pending <= 1'b1;
        end
        if (load) begin
          cur_valid  <= 1'b1;
          next_valid <= 1'b0;
        end else if (consume) begin
          half_idx <= ~half_idx;
          if (half_idx) begin
            cur_valid <= 1'b0;
          end
        end
      end
    end
  end

  always_ff @(posedge CLK_50M) begin
    if (issue) begin
      fetch_addr <= addr;
    end
    if (load) begin
      cur_word <= fetch_word;
    end
    if (consume) begin
      audio_data <= cur_word.half[half_sel][HALF_W-1 -: ipod_pkg::SAMPLE_W];
    end
  end

endmodule

/* src/ipod_top.sv */
`timescale 1ns/100ps

module ipod_top #(
  parameter int LAST_WORD_ADDR     = 'h7FFFF,
  parameter int DEFAULT_SAMPLE_DIV = 1136,
  parameter int SPEED_STEP         = 100
) (
  input  logic                              CLK_50M,
  input  logic                              rst,
  input  logic [7:0]                        cmd_ascii,
  input  logic                              cmd_valid,
  input  logic                              speed_up,
  input  logic                              speed_down,
  input  logic                              speed_reset,
  output logic                              flash_read,
  output logic [ipod_pkg::FLASH_ADDR_W-1:0] flash_address,
  input  logic                              flash_waitrequest,
  input  logic [ipod_pkg::FLASH_DATA_W-1:0] flash_readdata,
  input  logic                              flash_readdatavalid,
  output logic [ipod_pkg::SAMPLE_W-1:0]     audio_data,
  output logic                              audio_valid,
  output logic                              playing
);

  logic                              play;
  logic                              reverse;
  logic                              restart;
  logic [ipod_pkg::PERIOD_W-1:0]     sample_period;
  logic                              tick;
  logic                              fetch_req;
  logic [ipod_pkg::FLASH_ADDR_W-1:0] fetch_addr;
  ipod_pkg::flash_word_t             fetch_word;
  logic                              fetch_done;

  // ==========================================================================
  // Control path
  // ==========================================================================

  kbd_command_decoder u_kbd_command_decoder (
    .CLK_50M   (CLK_50M),
    .rst       (rst),
    .cmd_ascii (cmd_ascii),
    .cmd_valid (cmd_valid),
    .play      (play),
    .reverse   (reverse),
    .restart   (restart)
  );

  playback_speed_control #(
    .DEFAULT_SAMPLE_DIV (DEFAULT_SAMPLE_DIV),
    .SPEED_STEP         (SPEED_STEP)
  ) u_playback_speed_control (
    .CLK_50M       (CLK_50M),
    .rst           (rst),
    .speed_up      (speed_up),
    .speed_down    (speed_down),
    .speed_reset   (speed_reset),
    .sample_period (sample_period)
  );

  sample_tick_gen u_sample_tick_gen (
    .CLK_50M       (CLK_50M),
    .rst           (rst),
    .sample_period (sample_period),
    .tick          (tick)
  );

  // ==========================================================================
  // Flash and sample path
  // ==========================================================================

  flash_word_reader u_flash_word_reader (
    .CLK_50M             (CLK_50M),
    .rst                 (rst),
    .fetch_req           (fetch_req),
    .fetch_addr          (fetch_addr),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .fetch_word          (fetch_word),
    .fetch_done          (fetch_done)
  );

  sample_sequencer #(
    .LAST_WORD_ADDR (LAST_WORD_ADDR)
  ) u_sample_sequencer (
    .CLK_50M     (CLK_50M),
    .rst         (rst),
    .play        (play),
    .reverse     (reverse),
    .restart     (restart),
    .tick        (tick),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .fetch_word  (fetch_word),
    .fetch_done  (fetch_done),
    .audio_data  (audio_data),
    .audio_valid (audio_valid),
    .playing     (playing)
  );

endmodule

/* sim/flash_model.sv */
`timescale 1ns/100ps

module flash_model (
  input  logic                              CLK_50M,
  input  logic                              rst,
  input  logic                              flash_read,
  input  logic [ipod_pkg::FLASH_ADDR_W-1:0] flash_address,
  output logic                              flash_waitrequest,
  output logic [ipod_pkg::FLASH_DATA_W-1:0] flash_readdata,
  output logic                              flash_readdatavalid
);

  logic [1:0]                        wait_left;
  logic [1:0]                        data_left;
  logic                              data_pend;
  logic [ipod_pkg::FLASH_ADDR_W-1:0] read_addr;

  // Samples 2a and 2a+1 sit in the upper bytes
  // Lower bytes fold in the rest of the address
  function automatic logic [ipod_pkg::FLASH_DATA_W-1:0] word_at(
    input logic [ipod_pkg::FLASH_ADDR_W-1:0] a
  );
    logic [7:0] lo_fill;
    logic [7:0] hi_fill;
    lo_fill = a[7:0] ^ a[15:8];
    hi_fill = {1'b0, a[22:16]} ^ 8'hA5;
    return {a[6:0], 1'b1, hi_fill, a[6:0], 1'b0, lo_fill};
  endfunction

  // Read is held off for 0 to 2 cycles
  assign flash_waitrequest = flash_read && (wait_left != 2'd0);

  always @(posedge CLK_50M) begin
    if (rst) begin
      wait_left           <= 2'($urandom_range(2, 0));
      data_left           <= 2'd0;
      data_pend           <= 1'b0;
      read_addr           <= '0;
      flash_readdata      <= '0;
      flash_readdatavalid <= 1'b0;
    end else begin
      flash_readdatavalid <= 1'b0;
      if (flash_read) begin
        if (wait_left != 2'd0) begin
          wait_left <= wait_left - 2'd1;
        end else begin
          // Accepted here, data follows 1 to 4 cycles later
          read_addr <= flash_address;
          data_left <= 2'($urandom_range(3, 0));
          data_pend <= 1'b1;
          wait_left <= 2'($urandom_range(2, 0));
        end
      end
      if (data_pend) begin
        if (data_left == 2'd0) begin
          flash_readdata      <= word_at(read_addr);
          flash_readdatavalid <= 1'b1;
          data_pend           <= 1'b0;
        end else begin
          data_left <= data_left - 2'd1;
        end
      end
    end
  end

endmodule

/* sim/tb_ipod_top.sv */
`timescale 1ns/100ps

module tb_ipod_top;

  localparam int LAST_WORD_ADDR     = 7;
  localparam int DEFAULT_SAMPLE_DIV = 40;
  localparam int SPEED_STEP         = 8;
  localparam int SAMPLE_TIMEOUT     = 400;
  // Two samples per word
  localparam int NUM_SAMPLES        = 2 * (LAST_WORD_ADDR + 1);

  localparam logic [2:0] SEL_UP    = 3'b100;
  localparam logic [2:0] SEL_DOWN  = 3'b010;
  localparam logic [2:0] SEL_RESET = 3'b001;

  logic                              CLK_50M;
  logic                              rst;
  logic [7:0]                        cmd_ascii;
  logic                              cmd_valid;
  logic                              speed_up;
  logic                              speed_down;
  logic                              speed_reset;
  logic                              flash_read;
  logic [ipod_pkg::FLASH_ADDR_W-1:0] flash_address;
  logic                              flash_waitrequest;
  logic [ipod_pkg::FLASH_DATA_W-1:0] flash_readdata;
  logic                              flash_readdatavalid;
  logic [ipod_pkg::SAMPLE_W-1:0]     audio_data;
  logic                              audio_valid;
  logic                              playing;

  logic [7:0] sample_q[$];
  int         stamp_q[$];
  int         cycle_count = 0;
  int         exp_val;
  logic       exp_rev;

  logic                              read_open;
  logic                              read_held;
  logic [ipod_pkg::FLASH_ADDR_W-1:0] held_addr;

  ipod_top #(
    .LAST_WORD_ADDR     (LAST_WORD_ADDR),
    .DEFAULT_SAMPLE_DIV (DEFAULT_SAMPLE_DIV),
    .SPEED_STEP         (SPEED_STEP)
  ) dut (
    .CLK_50M             (CLK_50M),
    .rst                 (rst),
    .cmd_ascii           (cmd_ascii),
    .cmd_valid           (cmd_valid),
    .speed_up            (speed_up),
    .speed_down          (speed_down),
    .speed_reset         (speed_reset),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .audio_data          (audio_data),
    .audio_valid         (audio_valid),
    .playing             (playing)
  );

  flash_model flash (
    .CLK_50M             (CLK_50M),
    .rst                 (rst),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid)
  );

  initial begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // Every audio sample with the cycle it appeared in
  always @(negedge CLK_50M) begin
    cycle_count = cycle_count + 1;
    if (audio_valid) begin
      sample_q.push_back(audio_data);
      stamp_q.push_back(cycle_count);
    end
  end

  // ==========================================================================
  // Checking and helpers
  // ==========================================================================

  task automatic fail_now();
    $display("Test failures found");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_value(input string name, input int actual, input int expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
      fail_now();
    end
  endtask

  // Flash bus rules, seen between clock edges
  always @(negedge CLK_50M) begin
    if (rst) begin
      read_open = 1'b0;
      read_held = 1'b0;
      held_addr = '0;
    end else begin
      // No new read while a word is still owed
      if (read_open) begin
        check_value("flash_read", int'(flash_read), 0);
      end
      // Held off reads keep their address
      if (read_held) begin
        check_value("flash_read", int'(flash_read), 1);
        check_value("flash_address", int'(flash_address), int'(held_addr));
      end
      if (flash_readdatavalid) begin
        read_open = 1'b0;
      end
      if (flash_read && !flash_waitrequest) begin
        read_open = 1'b1;
      end
      read_held = flash_read && flash_waitrequest;
      held_addr = flash_address;
    end
  end

  function automatic int next_sample(input int cur, input logic rev);
    if (rev) begin
      return (cur + NUM_SAMPLES - 1) % NUM_SAMPLES;
    end else begin
      return (cur + 1) % NUM_SAMPLES;
    end
  endfunction

  task automatic send_cmd(input logic [7:0] code);
    @(posedge CLK_50M);
    cmd_ascii <= code;
    cmd_valid <= 1'b1;
    @(posedge CLK_50M);
    cmd_valid <= 1'b0;
    // Let a sample already in flight land in the queue
    repeat (3) @(posedge CLK_50M);
  endtask

  task automatic pulse_speed(input logic [2:0] sel);
    @(posedge CLK_50M);
    {speed_up, speed_down, speed_reset} <= sel;
    @(posedge CLK_50M);
    {speed_up, speed_down, speed_reset} <= 3'b000;
  endtask

  task automatic check_playing(input logic expected);
    @(negedge CLK_50M);
    check_value("playing", int'(playing), int'(expected));
  endtask

  task automatic take_one(output int stamp);
    int         waited;
    logic [7:0] value;
    waited = 0;
    stamp  = 0;
    while (sample_q.size() == 0 && waited < SAMPLE_TIMEOUT) begin
      @(posedge CLK_50M);
      waited++;
    end
    if (sample_q.size() == 0) begin
      $display("No audio sample arrived within %0d cycles", SAMPLE_TIMEOUT);
      fail_now();
    end else begin
      value = sample_q.pop_front();
      stamp = stamp_q.pop_front();
      check_value("audio_data", int'(value), exp_val);
      exp_val = next_sample(exp_val, exp_rev);
    end
  endtask

  task automatic take_checked(input int count);
    int stamp;
    repeat (count) take_one(stamp);
  endtask

  task automatic drain_checked();
    int stamp;
    while (sample_q.size() > 0) begin
      take_one(stamp);
    end
  endtask

  task automatic drain_unchecked();
    sample_q.delete();
    stamp_q.delete();
  endtask

  // Skips two samples so the new period has reached the tick counter
  task automatic measure_spacing(input int expected);
    int unused;
    int first;
    int second;
    int third;
    drain_checked();
    take_one(unused);
    take_one(unused);
    take_one(first);
    take_one(second);
    take_one(third);
    check_value("audio_valid spacing", second - first, expected);
    check_value("audio_valid spacing", third - second, expected);
  endtask

  // ==========================================================================
  // Tests
  // ==========================================================================

  task automatic test_forward_play();
    check_playing(1'b0);
    send_cmd("E");
    check_playing(1'b1);
    exp_val = 0;
    exp_rev = 1'b0;
    take_checked(NUM_SAMPLES + 4);
  endtask

  task automatic test_reverse_restart();
    send_cmd("B");
    send_cmd("R");
    drain_unchecked();
    exp_val = NUM_SAMPLES - 1;
    exp_rev = 1'b1;
    take_checked(NUM_SAMPLES + 4);
  endtask

  task automatic test_stop_resume();
    send_cmd("D");
    check_playing(1'b0);
    drain_checked();
    repeat (5 * DEFAULT_SAMPLE_DIV) @(posedge CLK_50M);
    check_value("samples while stopped", sample_q.size(), 0);
    send_cmd("E");
    check_playing(1'b1);
    take_checked(6);
  endtask

  task automatic test_restart_and_unknown();
    send_cmd("F");
    send_cmd("R");
    drain_unchecked();
    exp_val = 0;
    exp_rev = 1'b0;
    take_checked(5);
    send_cmd("x");
    check_playing(1'b1);
    take_checked(8);
  endtask

  task automatic test_speed();
    measure_spacing(DEFAULT_SAMPLE_DIV);
    pulse_speed(SEL_UP);
    measure_spacing(DEFAULT_SAMPLE_DIV - SPEED_STEP);
    pulse_speed(SEL_RESET);
    measure_spacing(DEFAULT_SAMPLE_DIV);
    pulse_speed(SEL_DOWN);
    measure_spacing(DEFAULT_SAMPLE_DIV + SPEED_STEP);
    pulse_speed(SEL_RESET);
    measure_spacing(DEFAULT_SAMPLE_DIV);
    // Six steps down from 40 hit the floor at one step
    repeat (6) pulse_speed(SEL_UP);
    measure_spacing(SPEED_STEP);
    pulse_speed(SEL_RESET);
    measure_spacing(DEFAULT_SAMPLE_DIV);
  endtask

  initial begin
    void'($urandom(32'haab6_5186));
    rst         = 1'b1;
    cmd_ascii   = 8'h00;
    cmd_valid   = 1'b0;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    exp_val     = 0;
    exp_rev     = 1'b0;
    repeat (4) @(posedge CLK_50M);
    rst <= 1'b0;

    test_forward_play();
    test_reverse_restart();
    test_stop_resume();
    test_restart_and_unknown();
    test_speed();

    $display("All tests passed!");
    $finish;
  end

endmodule

/* ipod_top.f */
src/ipod_pkg.sv
src/kbd_command_decoder.sv
src/playback_speed_control.sv
src/sample_tick_gen.sv
src/flash_word_reader.sv
src/sample_sequencer.sv
src/ipod_top.sv
sim/flash_model.sv
sim/tb_ipod_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and judge the log
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 -Wno-fatal --top-module tb_ipod_top -f ipod_top.f -o Vtb_ipod_top

# The log decides the result, so a nonzero exit from the run is tolerated here
./obj_dir/Vtb_ipod_top > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failures found" sim.log; then
  echo "Simulation reported errors"
  exit 1
fi

if ! grep -q "All tests passed!" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

echo "Simulation clean"
